// ==== logic/audio_pkg.sv ====
package audio_pkg;

    // sample and frame format
    localparam int SAMPLE_W = 24;           // bits per channel sample

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;          // upper half, sent in the lrclk low slot
        logic [SAMPLE_W-1:0] right;         // lower half, sent in the lrclk high slot
    } audio_frame_t;

    // sample fifo
    localparam int FIFO_DEPTH = 8;          // frames
    localparam int LEVEL_W    = 4;          // holds 0..FIFO_DEPTH

    // i2s timing, all derived from clk_soc
    localparam int BCLK_HALF = 4;           // clk_soc cycles per bclk half period
    localparam int SLOT_BITS = 32;          // bclks per channel slot, 64 per frame

    // reset stretch after the button is released
    localparam logic [5:0] RST_STRETCH = 6'd32;

    // register map, byte offsets
    localparam logic [7:0] REG_LED     = 8'h00;  // rw
    localparam logic [7:0] REG_INPUT   = 8'h04;  // ro, dip and buttons
    localparam logic [7:0] REG_AUDIO_L = 8'h08;  // wo, staged left sample
    localparam logic [7:0] REG_AUDIO_R = 8'h0C;  // wo, right sample and push
    localparam logic [7:0] REG_STATUS  = 8'h10;  // fifo state, overflow clear on write

    // status register bits
    localparam int ST_FULL      = 0;
    localparam int ST_EMPTY     = 1;
    localparam int ST_OVERFLOW  = 2;        // sticky
    localparam int ST_LEVEL_LSB = 4;        // level sits in LEVEL_W bits from here

endpackage

// ==== logic/bus_ifs.sv ====
// pipelined wishbone slave side, one request per stb cycle
// every request is acked exactly one cycle later, so no stall and no err
interface wb_slave_if;

    logic [31:0] addr;      // byte address, only the low byte is decoded
    logic [31:0] wdata;
    logic [3:0]  sel;       // byte enables
    logic        we;        // 1 = write
    logic        stb;       // request valid this cycle
    logic        ack;       // one cycle after stb
    logic [31:0] rdata;     // valid while ack is high

    modport master (
        output addr,
        output wdata,
        output sel,
        output we,
        output stb,
        input  ack,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  sel,
        input  we,
        input  stb,
        output ack,
        output rdata
    );

endinterface

// push side of the sample fifo
interface sample_wr_if;

    logic                           push;   // one frame per cycle
    audio_pkg::audio_frame_t        frame;
    logic                           full;   // push is ignored while high
    logic [audio_pkg::LEVEL_W-1:0]  level;  // frames stored

    modport master (output push, output frame, input full, input level);

    modport fifo (input push, input frame, output full, output level);

endinterface

// ==== logic/sample_fifo.sv ====
module sample_fifo (
    input  logic                    clk_i,
    input  logic                    rst_i,
    sample_wr_if.fifo               wr,
    input  logic                    pop_i,
    output audio_pkg::audio_frame_t frame_o,      // head frame, valid when not empty
    output logic                    empty_o
);

    audio_pkg::audio_frame_t mem [audio_pkg::FIFO_DEPTH];   // circular buffer

    logic [$clog2(audio_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(audio_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [audio_pkg::LEVEL_W-1:0]            level;
    logic                                     do_push;
    logic                                     do_pop;

    assign wr.full  = (level == audio_pkg::FIFO_DEPTH);
    assign wr.level = level;
    assign empty_o  = (level == '0);
    assign frame_o  = mem[rd_ptr];              // show-ahead read

    assign do_push = wr.push && !wr.full;       // push into a full fifo is lost
    assign do_pop  = pop_i && !empty_o;

    // pointers wrap by themselves, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;                      // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push)
            mem[wr_ptr] <= wr.frame;
    end

endmodule

// ==== logic/i2s_serializer.sv ====
module i2s_serializer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  audio_pkg::audio_frame_t frame_i,      // fifo head
    input  logic                    empty_i,
    output logic                    pop_o,        // takes the head at frame start
    output logic                    bclk_o,
    output logic                    lrclk_o,      // low = left slot
    output logic                    sdata_o
);

    localparam int CNT_W  = $clog2(2 * audio_pkg::SLOT_BITS);
    localparam int SLOT_W = $clog2(audio_pkg::SLOT_BITS);

    logic [$clog2(audio_pkg::BCLK_HALF)-1:0] div_cnt;  // clk_soc cycles within a bclk half
    logic [CNT_W-1:0]                        bit_cnt;  // bclk index within the frame
    logic [audio_pkg::SLOT_BITS-1:0]         shreg;    // msb goes out next
    logic [audio_pkg::SAMPLE_W-1:0]          right_hold;

    logic half_done;
    logic fall_tick;      // bclk falls on this edge
    logic slot_end;       // last bclk of a slot
    logic frame_start;    // left slot begins
    logic right_start;    // right slot begins

    // sample left aligned in a slot, padded with zeros
    function automatic logic [audio_pkg::SLOT_BITS-1:0] slot_word(
        input logic [audio_pkg::SAMPLE_W-1:0] sample
    );
        return {sample, {(audio_pkg::SLOT_BITS - audio_pkg::SAMPLE_W){1'b0}}};
    endfunction

    assign half_done   = (div_cnt == audio_pkg::BCLK_HALF - 1);
    assign fall_tick   = half_done && bclk_o;
    assign slot_end    = (bit_cnt[SLOT_W-1:0] == '1);
    assign frame_start = fall_tick && slot_end && bit_cnt[CNT_W-1];
    assign right_start = fall_tick && slot_end && !bit_cnt[CNT_W-1];

    assign pop_o   = frame_start && !empty_i;   // no data means a silent frame
    assign lrclk_o = bit_cnt[CNT_W-1];          // upper half of the frame is the right slot

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_cnt <= '0;
            bclk_o  <= 1'b0;
            bit_cnt <= '1;          // parks in the last right bit, lrclk high
            shreg   <= '0;
            sdata_o <= 1'b0;
        end else begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;
            if (half_done)
                bclk_o <= ~bclk_o;

            // everything moves on the falling bclk edge
            if (fall_tick) begin
                bit_cnt <= bit_cnt + 1'b1;
                sdata_o <= shreg[audio_pkg::SLOT_BITS-1];   // one bit late, i2s delay
                if (frame_start)
                    shreg <= pop_o ? slot_word(frame_i.left) : '0;
                else if (right_start)
                    shreg <= slot_word(right_hold);
                else
                    shreg <= shreg << 1;
            end
        end
    end

    // right sample waits here for half a frame
    always_ff @(posedge clk_i) begin
        if (frame_start)
            right_hold <= pop_o ? frame_i.right : '0;
    end

endmodule

// ==== logic/wb_audio_regs.sv ====
module wb_audio_regs (
    input  logic         clk_i,
    input  logic         rst_i,
    wb_slave_if.slave    bus,
    sample_wr_if.master  wr,
    input  logic [7:0]   dip_i,
    input  logic [4:0]   btn_i,
    output logic [7:0]   led_o
);

    logic [7:0]                     offset;       // byte offset inside the block
    logic                           wr_req;
    logic                           rd_req;
    logic                           fifo_busy;    // the next push would not fit
    logic                           empty;
    logic                           overflow;     // sticky, a frame was dropped
    logic [audio_pkg::SAMPLE_W-1:0] left_stage;   // left sample waiting for its right
    logic [31:0]                    status_word;
    logic [31:0]                    rdata_next;

    assign offset = bus.addr[7:0];
    assign wr_req = bus.stb && bus.we;
    assign rd_req = bus.stb && !bus.we;
    assign empty  = (wr.level == '0);

    // a push issued last cycle is not in the level yet
    // counting it keeps our drop decision equal to what the fifo does
    assign fifo_busy = wr.full ||
                       (wr.push && wr.level == audio_pkg::FIFO_DEPTH - 1);

    // control state, ack always one cycle after stb
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus.ack  <= 1'b0;
            wr.push  <= 1'b0;
            led_o    <= '0;
            overflow <= 1'b0;
        end else begin
            bus.ack <= bus.stb;
            wr.push <= 1'b0;                    // single cycle pulse
            if (wr_req) begin
                case (offset)
                    audio_pkg::REG_LED: begin
                        if (bus.sel[0])
                            led_o <= bus.wdata[7:0];
                    end
                    audio_pkg::REG_AUDIO_R: begin
                        if (fifo_busy)
                            overflow <= 1'b1;   // frame dropped, bus still acks
                        else
                            wr.push <= 1'b1;
                    end
                    audio_pkg::REG_STATUS: begin
                        if (bus.wdata[audio_pkg::ST_OVERFLOW])
                            overflow <= 1'b0;   // write one to clear
                    end
                    default: ;                  // ro and unmapped writes do nothing
                endcase
            end
        end
    end

    // sample payload, frame goes out together with the push pulse
    always_ff @(posedge clk_i) begin
        if (wr_req && offset == audio_pkg::REG_AUDIO_L)
            left_stage <= bus.wdata[audio_pkg::SAMPLE_W-1:0];
        if (wr_req && offset == audio_pkg::REG_AUDIO_R) begin
            wr.frame.left  <= left_stage;
            wr.frame.right <= bus.wdata[audio_pkg::SAMPLE_W-1:0];
        end
    end

    always_comb begin
        status_word = '0;
        status_word[audio_pkg::ST_FULL]     = wr.full;
        status_word[audio_pkg::ST_EMPTY]    = empty;
        status_word[audio_pkg::ST_OVERFLOW] = overflow;
        status_word[audio_pkg::ST_LEVEL_LSB +: audio_pkg::LEVEL_W] = wr.level;
    end

    // read mux, unmapped and write-only offsets read as zero
    always_comb begin
        case (offset)
            audio_pkg::REG_LED:    rdata_next = {24'h0, led_o};
            audio_pkg::REG_INPUT:  rdata_next = {19'h0, btn_i, dip_i};
            audio_pkg::REG_STATUS: rdata_next = status_word;
            default:               rdata_next = '0;
        endcase
    end

    // read data lands together with ack
    always_ff @(posedge clk_i) begin
        bus.rdata <= rd_req ? rdata_next : '0;
    end

endmodule

// ==== logic/audio_subsys_top.sv ====
module audio_subsys_top (
    input  logic        clk_soc,
    input  logic        btn_rst,
    input  logic [31:0] wb_addr_i,
    input  logic [31:0] wb_wdata_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_rdata_o,
    input  logic [7:0]  dip_i,
    input  logic [4:0]  btn_i,
    output logic [7:0]  led_o,
    output logic        bclk_o,
    output logic        lrclk_o,
    output logic        sdata_o
);

    // counts down after the button is let go, starts loaded at power up
    logic [$bits(audio_pkg::RST_STRETCH)-1:0] rst_cnt = audio_pkg::RST_STRETCH;
    logic                                     rst_int;

    audio_pkg::audio_frame_t fifo_frame;      // fifo head to serializer
    logic                    fifo_empty;
    logic                    fifo_pop;

    always_ff @(posedge clk_soc) begin
        if (btn_rst)
            rst_cnt <= audio_pkg::RST_STRETCH;
        else if (rst_cnt != '0)
            rst_cnt <= rst_cnt - 1'b1;
    end

    assign rst_int = btn_rst || (rst_cnt != '0);

    wb_slave_if  wb_bus ();
    sample_wr_if smp_wr ();

    // plain bus ports onto the interface, master side
    assign wb_bus.addr  = wb_addr_i;
    assign wb_bus.wdata = wb_wdata_i;
    assign wb_bus.sel   = wb_sel_i;
    assign wb_bus.we    = wb_we_i;
    assign wb_bus.stb   = wb_stb_i;
    assign wb_ack_o     = wb_bus.ack;
    assign wb_rdata_o   = wb_bus.rdata;

    wb_audio_regs regs_inst (
        .clk_i (clk_soc),
        .rst_i (rst_int),
        .bus   (wb_bus.slave),
        .wr    (smp_wr.master),
        .dip_i (dip_i),
        .btn_i (btn_i),
        .led_o (led_o)
    );

    sample_fifo fifo_inst (
        .clk_i   (clk_soc),
        .rst_i   (rst_int),
        .wr      (smp_wr.fifo),
        .pop_i   (fifo_pop),
        .frame_o (fifo_frame),
        .empty_o (fifo_empty)
    );

    i2s_serializer i2s_inst (
        .clk_i   (clk_soc),
        .rst_i   (rst_int),
        .frame_i (fifo_frame),
        .empty_i (fifo_empty),
        .pop_o   (fifo_pop),
        .bclk_o  (bclk_o),
        .lrclk_o (lrclk_o),
        .sdata_o (sdata_o)
    );

endmodule

// ==== testbench/tb_audio_subsys.sv ====
module tb_audio_subsys;

    localparam int DRV        = 10;                      // input skew after posedge
    localparam int MAX_CYCLES = 20000;                   // about 3x the 14 frames and bus traffic

    logic        clk_soc = 1'b0;
    logic        btn_rst;
    logic [31:0] wb_addr_i;
    logic [31:0] wb_wdata_i;
    logic [3:0]  wb_sel_i;
    logic        wb_we_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    logic [31:0] wb_rdata_o;
    logic [7:0]  dip_i;
    logic [4:0]  btn_i;
    logic [7:0]  led_o;
    logic        bclk_o;
    logic        lrclk_o;
    logic        sdata_o;

    audio_pkg::audio_frame_t exp_q[$];           // written and not started yet
    audio_pkg::audio_frame_t want = '0;          // content of the frame now playing
    logic [31:0] rng = 32'd32895;
    logic [31:0] slot_shift = '0;                // bits of the running slot
    logic [31:0] left_word;
    logic        lr_prev = 1'b1;
    logic        have_frame = 1'b0;              // a full frame start was seen
    logic        mon_en = 1'b0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          frames_seen = 0;
    int          cycle_cnt = 0;
    string       cur_test = "reset";

    audio_subsys_top audio_subsys_top_inst (.*);

    always #50 clk_soc = ~clk_soc;

    always @(posedge clk_soc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles in test %s", cycle_cnt, cur_test);
            $display("Test failed");
            $finish;
        end
    end

    // ack exactly one cycle after each stb and never without one
    ack_latency: assert property (@(posedge clk_soc) disable iff (btn_rst)
                                  wb_ack_o == $past(wb_stb_i))
        else begin
            errors++;
            $display("ERROR %s: ack does not follow stb by exactly one cycle", cur_test);
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // status word as the register map lays it out
    function automatic logic [31:0] status_value(input logic ovf, input int level);
        logic [31:0] v;
        v = '0;
        v[audio_pkg::ST_FULL]     = (level == audio_pkg::FIFO_DEPTH);
        v[audio_pkg::ST_EMPTY]    = (level == 0);
        v[audio_pkg::ST_OVERFLOW] = ovf;
        v[audio_pkg::ST_LEVEL_LSB +: audio_pkg::LEVEL_W] = level[audio_pkg::LEVEL_W-1:0];
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] got);
        assert (got === exp_v)
        else begin
            errors++;
            $display("ERROR %s: %s expected %h, actual %h", cur_test, what, exp_v, got);
        end
    endtask

    // one request with stb high for a single cycle and a wait for ack
    task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk_soc);
        #DRV;
        wb_addr_i  = addr;
        wb_wdata_i = wdata;
        wb_sel_i   = sel;
        wb_we_i    = we;
        wb_stb_i   = 1'b1;
        @(posedge clk_soc);                      // accepted here
        #DRV;
        wb_stb_i = 1'b0;
        while (!wb_ack_o && waited < 8) begin
            @(posedge clk_soc);
            #DRV;
            waited++;
        end
        assert (wb_ack_o)
        else begin
            errors++;
            $display("ERROR %s: request to %h never got an ack", cur_test, addr);
        end
        rdata = wb_rdata_o;                      // valid while ack is high
    endtask

    task automatic write_frame(output audio_pkg::audio_frame_t f);
        logic [31:0] unused;
        rng     = xorshift(rng);
        f.left  = rng[23:0];
        rng     = xorshift(rng);
        f.right = rng[23:0];
        bus_access(1'b1, audio_pkg::REG_AUDIO_L, {8'h0, f.left}, 4'hF, unused);
        bus_access(1'b1, audio_pkg::REG_AUDIO_R, {8'h0, f.right}, 4'hF, unused);
    endtask

    // wait until the queued frames and one silent frame are checked
    task automatic wait_drained();
        int target;
        while (exp_q.size() != 0)
            @(posedge clk_soc);
        target = frames_seen + 2;
        while (frames_seen < target)
            @(posedge clk_soc);
    endtask

    // print the result of the running test and open the next one
    task automatic next_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: PASS", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", cur_test, errors - test_errors);
        end
        cur_test    = name;
        test_errors = errors;
    endtask

    // i2s decode on rising bclk
    // the bit right after an lrclk edge closes the old slot
    always @(posedge bclk_o) begin
        if (mon_en) begin
            slot_shift = {slot_shift[30:0], sdata_o};
            if (lrclk_o && !lr_prev) begin
                left_word = slot_shift;
            end else if (!lrclk_o && lr_prev) begin
                if (have_frame) begin
                    check_value("left sample", want.left, left_word[31:8]);
                    check_value("right sample", want.right, slot_shift[31:8]);
                    check_value("slot padding", 0, {left_word[7:0], slot_shift[7:0]});
                    frames_seen++;
                end
                if (exp_q.size() != 0)
                    want = exp_q.pop_front();    // oldest written frame plays now
                else
                    want = '0;                   // silence
                have_frame = 1'b1;
            end
            if (lrclk_o != lr_prev)
                slot_shift = '0;
            lr_prev = lrclk_o;
        end
    end

    initial begin
        logic [31:0]             rd;
        audio_pkg::audio_frame_t f;
        int                      level_model;
        int                      dropped;
        btn_rst     = 1'b1;
        wb_addr_i   = '0;
        wb_wdata_i  = '0;
        wb_sel_i    = '0;
        wb_we_i     = 1'b0;
        wb_stb_i    = 1'b0;
        dip_i       = '0;
        btn_i       = '0;
        level_model = 0;                         // fifo starts empty
        dropped     = 0;
        repeat (16) @(posedge clk_soc);
        #DRV btn_rst = 1'b0;
        mon_en = 1'b1;
        repeat (audio_pkg::RST_STRETCH + 2) @(posedge clk_soc);   // i2s not running yet
        #DRV;
        check_value("led_o", 0, led_o);
        check_value("lrclk_o", 1, lrclk_o);
        check_value("bclk_o", 0, bclk_o);
        bus_access(1'b0, audio_pkg::REG_STATUS, 0, 4'hF, rd);
        check_value("status", status_value(1'b0, 0), rd);

        next_test("led");
        bus_access(1'b1, audio_pkg::REG_LED, 32'hA5, 4'hF, rd);
        check_value("led_o", 32'hA5, led_o);
        bus_access(1'b0, audio_pkg::REG_LED, 0, 4'hF, rd);
        check_value("led readback", 32'hA5, rd);
        bus_access(1'b1, audio_pkg::REG_LED, 32'h3C, 4'b1110, rd);   // byte 0 disabled
        check_value("led_o after masked write", 32'hA5, led_o);
        bus_access(1'b0, 32'h40, 0, 4'hF, rd);
        check_value("unmapped read", 0, rd);

        next_test("inputs");
        repeat (4) begin
            rng   = xorshift(rng);
            dip_i = rng[7:0];
            btn_i = rng[12:8];
            bus_access(1'b0, audio_pkg::REG_INPUT, 0, 4'hF, rd);
            check_value("input word", {19'h0, rng[12:8], rng[7:0]}, rd);
        end

        next_test("playback");
        @(negedge lrclk_o);
        @(posedge bclk_o);                       // this frame's content is fixed now
        repeat (3) begin
            write_frame(f);
            exp_q.push_back(f);
        end
        wait_drained();
        bus_access(1'b0, audio_pkg::REG_STATUS, 0, 4'hF, rd);
        check_value("status after playback", status_value(1'b0, 0), rd);

        next_test("overflow");
        @(negedge lrclk_o);
        @(posedge bclk_o);
        repeat (10) begin                        // all within one frame time
            write_frame(f);
            if (level_model < audio_pkg::FIFO_DEPTH) begin
                exp_q.push_back(f);
                level_model++;
            end else begin
                dropped++;
            end
        end
        bus_access(1'b0, audio_pkg::REG_STATUS, 0, 4'hF, rd);
        check_value("status after burst", status_value(dropped != 0, level_model), rd);
        bus_access(1'b1, audio_pkg::REG_STATUS, 32'h1 << audio_pkg::ST_OVERFLOW, 4'hF, rd);
        bus_access(1'b0, audio_pkg::REG_STATUS, 0, 4'hF, rd);
        check_value("status after clear", status_value(1'b0, level_model), rd);
        wait_drained();

        next_test("");
        $display("%0d of %0d tests passed, %0d errors", tests_passed,
                 tests_passed + tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== project.f ====
logic/audio_pkg.sv
logic/bus_ifs.sv
logic/sample_fifo.sv
logic/i2s_serializer.sv
logic/wb_audio_regs.sv
logic/audio_subsys_top.sv
testbench/tb_audio_subsys.sv

// ==== Bender.yml ====
package:
  name: audio_subsys

sources:
  # design, package and interfaces first
  - files:
      - logic/audio_pkg.sv
      - logic/bus_ifs.sv
      - logic/sample_fifo.sv
      - logic/i2s_serializer.sv
      - logic/wb_audio_regs.sv
      - logic/audio_subsys_top.sv

  # testbench, top module tb_audio_subsys
  - target: test
    files:
      - testbench/tb_audio_subsys.sv
